// File: logic/dvi_consts.svh
// Video timing constants for the 640x480 at 60 Hz mode
// TMDS control words for the blanking periods
`ifndef DVI_CONSTS_SVH
`define DVI_CONSTS_SVH

// Horizontal timing in pixel clocks
// The sync pulse covers pixels 656 up to 751
`define H_ACTIVE     640
`define H_SYNC_START 656
`define H_SYNC_END   752
`define H_TOTAL      800

// Vertical timing in lines
// The sync pulse covers lines 490 and 491
`define V_ACTIVE     480
`define V_SYNC_START 490
`define V_SYNC_END   492
`define V_TOTAL      525

// Counters are divided by four to give the coarse pixel coordinate
`define COORD_SHIFT  2

// Control words sent during blanking, indexed by {vSync, hSync}
`define TMDS_CTRL_00 10'b1101010100
`define TMDS_CTRL_01 10'b0010101011
`define TMDS_CTRL_10 10'b0101010100
`define TMDS_CTRL_11 10'b1010101011

`endif

// File: logic/dviPkg.sv
// Shared types of the DVI transmitter
// Pixel, sync and symbol structs plus the encoder enums
`default_nettype none

package dviPkg;

   // One pixel at 8 bits per colour
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb888T;

   // Display enable and both sync levels, all active high
   typedef struct packed {
      logic de;
      logic hSync;
      logic vSync;
   } syncT;

   // One 10-bit TMDS symbol for each channel
   typedef struct packed {
      logic [9:0] red;
      logic [9:0] green;
      logic [9:0] blue;
   } tmdsSymbolsT;

   // Symbol class chosen from the display enable
   typedef enum logic {
      modeControl,
      modeVideo
   } tmdsModeE;

   // The three DC-balance decisions of the second encoder stage
   // Neutral when nothing is to be corrected, Correct to invert, Keep to pass through
   typedef enum logic [1:0] {
      balNeutral,
      balCorrect,
      balKeep
   } balanceCaseE;

endpackage

`default_nettype wire

// File: logic/videoTiming.sv
// Raster timing generator for 640x480 at 60 Hz
// Pixel and line counters, registered sync and display enable, coarse coordinates
// and the start-of-frame strobe
`timescale 1ns/100ps
`default_nettype none

`include "dvi_consts.svh"

module videoTiming import dviPkg::*; (
   input  logic       pixclk,
   input  logic       arstN,
   output syncT       sync,
   output logic [7:0] x,
   output logic [7:0] y,
   output logic       newFrame
);

   // Last values before each counter wraps
   localparam logic [9:0] H_LAST = 10'(`H_TOTAL - 1);
   localparam logic [9:0] V_LAST = 10'(`V_TOTAL - 1);

   // Pixel position inside the line and line position inside the frame
   logic [9:0] hCount;
   logic [9:0] vCount;

   // Level decodes of the current counter position
   logic       inActive;
   logic       inHSync;
   logic       inVSync;
   logic       atOrigin;

   // The pixel counter runs every cycle and wraps after 800 pixels
   // The line counter moves on only when a line ends
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         hCount <= '0;
         vCount <= '0;
      end else begin
         if (hCount == H_LAST) begin
            hCount <= '0;
            if (vCount == V_LAST) begin
               vCount <= '0;
            end else begin
               vCount <= vCount + 10'd1;
            end
         end else begin
            hCount <= hCount + 10'd1;
         end
      end
   end

   // Decode the ranges from the counters
   // Both sync windows end one position before their END constant
   assign inActive = (hCount < `H_ACTIVE) && (vCount < `V_ACTIVE);
   assign inHSync  = (hCount >= `H_SYNC_START) && (hCount < `H_SYNC_END);
   assign inVSync  = (vCount >= `V_SYNC_START) && (vCount < `V_SYNC_END);
   assign atOrigin = (hCount == 10'd0) && (vCount == 10'd0);

   // The sync levels and the frame strobe describe the counter value of the previous cycle
   // The colour register in the top level has the same one-cycle delay
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         sync     <= '0;
         newFrame <= 1'b0;
      end else begin
         sync.de    <= inActive;
         sync.hSync <= inHSync;
         sync.vSync <= inVSync;
         newFrame   <= atOrigin;
      end
   end

   // Coarse coordinates go straight from the counters
   // The largest values are 199 and 131 so eight bits are enough
   assign x = 8'(hCount >> `COORD_SHIFT);
   assign y = 8'(vCount >> `COORD_SHIFT);

   // Neither counter may ever reach its total
   counterBounds: assert property (
      @(posedge pixclk) disable iff (!arstN)
      (hCount < `H_TOTAL) && (vCount < `V_TOTAL)
   ) else $error("Raster counter out of range h=%0d v=%0d", hCount, vCount);

endmodule

`default_nettype wire

// File: logic/tmdsEncoder.sv
// Single-channel TMDS encoder
// Transition minimisation, DC balance with a running disparity register,
// control words during blanking, and the checks on disparity and control symbols
`timescale 1ns/100ps
`default_nettype none

`include "dvi_consts.svh"

module tmdsEncoder import dviPkg::*; (
   input  logic       pixclk,
   input  logic       arstN,
   input  logic [7:0] videoData,
   input  logic [1:0] ctrlData,
   input  logic       de,
   output logic [9:0] symbol
);

   // Counts the ones in a byte
   function automatic logic [3:0] countOnes(input logic [7:0] value);
      logic [3:0] total;
      total = 4'd0;
      for (int i = 0; i < 8; i++) begin
         total = total + 4'(value[i]);
      end
      return total;
   endfunction

   // Ones in the input byte and choice of chaining
   logic [3:0]        onesIn;
   logic              useXnor;

   // Intermediate 9-bit word after stage one
   logic [8:0]        qm;
   logic [3:0]        onesQm;
   logic [3:0]        zerosQm;

   // Ones minus zeros of the intermediate byte, always even
   logic signed [5:0] qmBalance;

   // Running disparity, ones sent minus zeros sent
   logic signed [5:0] disparity;
   logic signed [5:0] nextDisparity;

   tmdsModeE          mode;
   balanceCaseE       balCase;
   logic [9:0]        videoSymbol;
   logic [9:0]        ctrlSymbol;

   // Stage one
   // A byte heavy in ones is chained with XNOR, the rest with XOR
   // Bit 8 tells the receiver which of the two was used
   assign onesIn  = countOnes(videoData);
   assign useXnor = (onesIn > 4'd4) || ((onesIn == 4'd4) && !videoData[0]);

   always_comb begin
      qm[0] = videoData[0];
      for (int i = 1; i < 8; i++) begin
         qm[i] = useXnor ? ~(qm[i-1] ^ videoData[i]) : (qm[i-1] ^ videoData[i]);
      end
      qm[8] = ~useXnor;
   end

   assign onesQm    = countOnes(qm[7:0]);
   assign zerosQm   = 4'd8 - onesQm;
   assign qmBalance = $signed({2'b00, onesQm}) - $signed({2'b00, zerosQm});

   // Stage two decision
   // With no history or a neutral word the choice follows bit 8
   // Invert when the word would push the disparity further the same way
   always_comb begin
      if ((disparity == 6'sd0) || (onesQm == zerosQm)) begin
         balCase = balNeutral;
      end else if (((disparity > 6'sd0) && (onesQm > zerosQm)) ||
                   ((disparity < 6'sd0) && (zerosQm > onesQm))) begin
         balCase = balCorrect;
      end else begin
         balCase = balKeep;
      end
   end

   // Build the video symbol and the disparity it leaves behind
   // Bit 9 marks an inverted data byte
   always_comb begin
      case (balCase)
         balNeutral: begin
            videoSymbol   = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            nextDisparity = qm[8] ? (disparity + qmBalance) : (disparity - qmBalance);
         end
         balCorrect: begin
            videoSymbol   = {1'b1, qm[8], ~qm[7:0]};
            nextDisparity = disparity - qmBalance + (qm[8] ? 6'sd2 : 6'sd0);
         end
         default: begin
            videoSymbol   = {1'b0, qm[8], qm[7:0]};
            nextDisparity = disparity + qmBalance - (qm[8] ? 6'sd0 : 6'sd2);
         end
      endcase
   end

   // Control word for blanking, picked by the two control bits
   always_comb begin
      case (ctrlData)
         2'b00:   ctrlSymbol = `TMDS_CTRL_00;
         2'b01:   ctrlSymbol = `TMDS_CTRL_01;
         2'b10:   ctrlSymbol = `TMDS_CTRL_10;
         default: ctrlSymbol = `TMDS_CTRL_11;
      endcase
   end

   assign mode = de ? modeVideo : modeControl;

   // One register stage for the symbol
   // Blanking clears the disparity so every active line starts balanced
   always_ff @(posedge pixclk or negedge arstN) begin
      if (!arstN) begin
         symbol    <= `TMDS_CTRL_00;
         disparity <= '0;
      end else begin
         if (mode == modeVideo) begin
            symbol    <= videoSymbol;
            disparity <= nextDisparity;
         end else begin
            symbol    <= ctrlSymbol;
            disparity <= '0;
         end
      end
   end

   // The disparity is a difference of two counts of ten bits and stays even and bounded
   disparityRange: assert property (
      @(posedge pixclk) disable iff (!arstN)
      !disparity[0] && (disparity <= 6'sd16) && (disparity >= -6'sd16)
   ) else $error("TMDS disparity out of range %0d", disparity);

   // A symbol taken during blanking is always one of the four control words
   blankingSymbol: assert property (
      @(posedge pixclk) disable iff (!arstN)
      $past(!de) |-> (symbol inside {`TMDS_CTRL_00, `TMDS_CTRL_01,
                                     `TMDS_CTRL_10, `TMDS_CTRL_11})
   ) else $error("Blanking symbol is not a control word %h", symbol);

endmodule

`default_nettype wire

// File: logic/dviTransmitter.sv
// Top level of the DVI transmitter front end
// Raster timing, RGB332 to RGB888 expansion and three TMDS channel encoders
// producing parallel 10-bit symbols for an external serializer
`timescale 1ns/100ps
`default_nettype none

module dviTransmitter import dviPkg::*; (
   input  logic        pixclk,
   input  logic        arstN,
   input  logic [7:0]  pixelData,
   output logic [7:0]  x,
   output logic [7:0]  y,
   output logic        newFrame,
   output tmdsSymbolsT tmdsSymbols
);

   // Sync levels for the pixel held in the colour register
   syncT       sync;

   // Expanded colour of the current pixel
   rgb888T     pixelRgb;

   // Symbols from the three encoders
   logic [9:0] redSymbol;
   logic [9:0] greenSymbol;
   logic [9:0] blueSymbol;

   // Control input of the blue channel
   logic [1:0] blueCtrl;

   // Raster timing
   // x and y come straight from the counters so the pixel source can answer
   // within the same cycle
   videoTiming timing_i (
      .pixclk   (pixclk),
      .arstN    (arstN),
      .sync     (sync),
      .x        (x),
      .y        (y),
      .newFrame (newFrame)
   );

   // Colour expansion from RGB332
   // Red and green keep three bits each, blue keeps two
   // The kept bits go to the top of each byte and the rest is zero
   // The register lines the colour up with the registered sync levels
   always_ff @(posedge pixclk) begin
      pixelRgb.red   <= {pixelData[7:5], 5'b0};
      pixelRgb.green <= {pixelData[4:2], 5'b0};
      pixelRgb.blue  <= {pixelData[1:0], 6'b0};
   end

   // Only blue carries the sync pulses in its control word
   assign blueCtrl = {sync.vSync, sync.hSync};

   // Red channel
   // Control input is tied low so blanking always sends the first control word
   tmdsEncoder redEnc_i (
      .pixclk    (pixclk),
      .arstN     (arstN),
      .videoData (pixelRgb.red),
      .ctrlData  (2'b00),
      .de        (sync.de),
      .symbol    (redSymbol)
   );

   // Green channel
   // Same as red, no control information here
   tmdsEncoder greenEnc_i (
      .pixclk    (pixclk),
      .arstN     (arstN),
      .videoData (pixelRgb.green),
      .ctrlData  (2'b00),
      .de        (sync.de),
      .symbol    (greenSymbol)
   );

   // Blue channel
   // Blanking sends the control word selected by vSync and hSync
   tmdsEncoder blueEnc_i (
      .pixclk    (pixclk),
      .arstN     (arstN),
      .videoData (pixelRgb.blue),
      .ctrlData  (blueCtrl),
      .de        (sync.de),
      .symbol    (blueSymbol)
   );

   // Gather the symbols for the serializer
   // Each symbol is two cycles behind the sampled byte and its sync levels
   assign tmdsSymbols.red   = redSymbol;
   assign tmdsSymbols.green = greenSymbol;
   assign tmdsSymbols.blue  = blueSymbol;

endmodule

`default_nettype wire

// File: verif/tmdsRefModel.svh
// Behavioural TMDS encoder used to predict the DUT symbols
// Running disparity per channel, control word lookup and symbol prediction
`ifndef TMDS_REF_MODEL_SVH
`define TMDS_REF_MODEL_SVH

// Disparity of red, green and blue, counted as ones minus zeros sent
int refDisparity [3];

// Control word for the pair {vSync, hSync}
function automatic logic [9:0] ctrlWord(input logic [1:0] vh);
   case (vh)
      2'b00:   return `TMDS_CTRL_00;
      2'b01:   return `TMDS_CTRL_01;
      2'b10:   return `TMDS_CTRL_10;
      default: return `TMDS_CTRL_11;
   endcase
endfunction

// Next symbol of one channel, with the disparity of that channel stepped
function automatic logic [9:0] refEncode(input int chan, input logic [7:0] data,
                                         input logic [1:0] ctrl, input logic de);
   logic [8:0] qm;
   logic       xnorMode;
   int         onesData;
   int         ones;
   int         zeros;
   // Blanking sends a control word and forgets the history
   if (!de) begin
      refDisparity[chan] = 0;
      return ctrlWord(ctrl);
   end
   // More than four ones, or exactly four with bit 0 clear, chains with XNOR
   onesData = $countones(data);
   xnorMode = (onesData > 4) || ((onesData == 4) && !data[0]);
   qm[0] = data[0];
   for (int i = 1; i < 8; i++) begin
      qm[i] = xnorMode ? (qm[i-1] ~^ data[i]) : (qm[i-1] ^ data[i]);
   end
   qm[8] = !xnorMode;
   ones  = $countones(qm[7:0]);
   zeros = 8 - ones;
   // No history or a neutral word, so bit 8 alone picks the inversion
   if ((refDisparity[chan] == 0) || (ones == zeros)) begin
      refDisparity[chan] += qm[8] ? (ones - zeros) : (zeros - ones);
      return {!qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
   end
   // The word leans the same way as the history and is sent inverted
   if (((refDisparity[chan] > 0) && (ones > zeros)) ||
       ((refDisparity[chan] < 0) && (zeros > ones))) begin
      refDisparity[chan] += 2 * int'(qm[8]) + zeros - ones;
      return {1'b1, qm[8], ~qm[7:0]};
   end
   refDisparity[chan] += ones - zeros - 2 * int'(!qm[8]);
   return {1'b0, qm[8], qm[7:0]};
endfunction

`endif

// File: verif/dviTransmitterTb.sv
// Testbench of the DVI transmitter front end
// Raster model, LCG pixel source, TMDS prediction and the directed tests
`timescale 1ns/100ps
`default_nettype none

`include "dvi_consts.svh"

module dviTransmitterTb import dviPkg::*; ();

   // A sampled byte together with the sync levels predicted for it
   typedef struct packed {
      logic [7:0] pixel;
      syncT       sync;
   } stageT;

   logic        pixclk;
   logic        arstN;
   logic [7:0]  pixelData;
   logic [7:0]  x;
   logic [7:0]  y;
   logic        newFrame;
   tmdsSymbolsT tmdsSymbols;

   // Model of the raster counters as they stand between two edges
   int          hModel;
   int          vModel;
   logic [31:0] lcgState;
   // Sampled bytes waiting for the encoders, the front one is encoded next
   stageT       pipe[$];
   stageT       expStage;
   logic        expNewFrame;
   tmdsSymbolsT expSymbols;

   `include "tmdsRefModel.svh"

   dviTransmitter dut_i (
      .pixclk      (pixclk),
      .arstN       (arstN),
      .pixelData   (pixelData),
      .x           (x),
      .y           (y),
      .newFrame    (newFrame),
      .tmdsSymbols (tmdsSymbols)
   );

   always #10 pixclk = ~pixclk;

   // Random pixel byte from the top bits of the generator
   function automatic logic [7:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState[31:24];
   endfunction

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp) else
         failRun($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // Everything at its reset value
   task automatic checkIdle();
      checkValue("x", 32'(x), 32'h0);
      checkValue("y", 32'(y), 32'h0);
      checkValue("newFrame", 32'(newFrame), 32'h0);
      checkValue("tmdsSymbols.red", 32'(tmdsSymbols.red), 32'(`TMDS_CTRL_00));
      checkValue("tmdsSymbols.green", 32'(tmdsSymbols.green), 32'(`TMDS_CTRL_00));
      checkValue("tmdsSymbols.blue", 32'(tmdsSymbols.blue), 32'(`TMDS_CTRL_00));
   endtask

   task automatic checkOutputs();
      checkValue("x", 32'(x), 32'(hModel >> `COORD_SHIFT));
      checkValue("y", 32'(y), 32'(vModel >> `COORD_SHIFT));
      checkValue("newFrame", 32'(newFrame), 32'(expNewFrame));
      checkValue("tmdsSymbols.red", 32'(tmdsSymbols.red), 32'(expSymbols.red));
      checkValue("tmdsSymbols.green", 32'(tmdsSymbols.green), 32'(expSymbols.green));
      checkValue("tmdsSymbols.blue", 32'(tmdsSymbols.blue), 32'(expSymbols.blue));
   endtask

   // One pixel clock, the rising edge samples and the falling edge checks
   task automatic tickCycle();
      stageT sampled;
      @(posedge pixclk);
      // The DUT takes the byte and the sync levels of the counters before this edge
      sampled.pixel      = pixelData;
      sampled.sync.de    = (hModel < `H_ACTIVE) && (vModel < `V_ACTIVE);
      sampled.sync.hSync = (hModel >= `H_SYNC_START) && (hModel < `H_SYNC_END);
      sampled.sync.vSync = (vModel >= `V_SYNC_START) && (vModel < `V_SYNC_END);
      expNewFrame = (hModel == 0) && (vModel == 0);
      pipe.push_back(sampled);
      expStage = pipe.pop_front();
      // RGB332 bits go to the top of each colour byte
      expSymbols.red   = refEncode(0, {expStage.pixel[7:5], 5'b0}, 2'b00, expStage.sync.de);
      expSymbols.green = refEncode(1, {expStage.pixel[4:2], 5'b0}, 2'b00, expStage.sync.de);
      expSymbols.blue  = refEncode(2, {expStage.pixel[1:0], 6'b0},
                                   {expStage.sync.vSync, expStage.sync.hSync},
                                   expStage.sync.de);
      if (hModel == `H_TOTAL - 1) begin
         hModel = 0;
         vModel = (vModel == `V_TOTAL - 1) ? 0 : vModel + 1;
      end else begin
         hModel++;
      end
      pixelData <= nextRandom();
      @(negedge pixclk);
      checkOutputs();
   endtask

   // Reset over two rising edges, checked during and just after
   task automatic resetState();
      @(negedge pixclk);
      checkIdle();
      @(posedge pixclk);
      arstN     <= 1'b1;
      pixelData <= nextRandom();
      @(negedge pixclk);
      checkIdle();
      hModel = 0;
      vModel = 0;
      refDisparity = '{0, 0, 0};
      // The encoders first see the reset sync levels
      pipe.delete();
      pipe.push_back('0);
   endtask

   // Four full lines of random pixels against the predicted symbols
   task automatic activeVideo();
      int videoCycles;
      videoCycles = 0;
      repeat (4 * `H_TOTAL) begin
         tickCycle();
         // Red leaves its blanking word only for a data symbol
         if (tmdsSymbols.red != `TMDS_CTRL_00) begin
            videoCycles++;
         end
      end
      assert (videoCycles == 4 * `H_ACTIVE) else
         failRun("Active video test did not see four full lines of pixels");
   endtask

   // One line from the start of horizontal blanking, control words taken from the macros
   task automatic blankingWords();
      int hSyncCycles;
      int guard;
      hSyncCycles = 0;
      guard = 0;
      while (hModel != `H_ACTIVE) begin
         tickCycle();
         guard++;
         assert (guard < `H_TOTAL) else failRun("Timeout waiting for horizontal blanking");
      end
      repeat (`H_TOTAL) begin
         tickCycle();
         if (!expStage.sync.de) begin
            checkValue("tmdsSymbols.red", 32'(tmdsSymbols.red), 32'(`TMDS_CTRL_00));
            checkValue("tmdsSymbols.green", 32'(tmdsSymbols.green), 32'(`TMDS_CTRL_00));
            checkValue("tmdsSymbols.blue", 32'(tmdsSymbols.blue),
                       32'(ctrlWord({expStage.sync.vSync, expStage.sync.hSync})));
            // Outside vertical sync the hSync pulse shows as the second control word
            if (tmdsSymbols.blue == `TMDS_CTRL_01) begin
               hSyncCycles++;
            end
         end
      end
      assert (hSyncCycles == `H_SYNC_END - `H_SYNC_START) else
         failRun("Horizontal sync window did not last 96 pixels");
   endtask

   // Coordinates follow the model every cycle, here the full x range is swept
   task automatic coordinates();
      int maxX;
      maxX = 0;
      repeat (`H_TOTAL) begin
         tickCycle();
         maxX = (int'(x) > maxX) ? int'(x) : maxX;
      end
      checkValue("largest x", 32'(maxX), 32'((`H_TOTAL - 1) >> `COORD_SHIFT));
   endtask

   // Distance between two frame strobes and the vertical sync words in between
   task automatic frameGeometry();
      int guard;
      int period;
      int vSyncCycles;
      guard = 0;
      period = 0;
      vSyncCycles = 0;
      while (!newFrame) begin
         tickCycle();
         guard++;
         assert (guard <= `H_TOTAL * `V_TOTAL) else failRun("Timeout waiting for newFrame");
      end
      do begin
         tickCycle();
         period++;
         if (expStage.sync.vSync) begin
            checkValue("tmdsSymbols.blue", 32'(tmdsSymbols.blue),
                       32'(ctrlWord({1'b1, expStage.sync.hSync})));
         end
         // Blue sends the vSync control words only on the two sync lines
         if ((tmdsSymbols.blue == `TMDS_CTRL_10) ||
             (tmdsSymbols.blue == `TMDS_CTRL_11)) begin
            vSyncCycles++;
         end
         assert (period <= `H_TOTAL * `V_TOTAL) else
            failRun("Timeout waiting for the next newFrame");
      end while (!newFrame);
      checkValue("frame period", 32'(period), 32'(`H_TOTAL * `V_TOTAL));
      assert (vSyncCycles == 2 * `H_TOTAL) else
         failRun("Vertical sync did not cover two full lines");
   endtask

   initial begin
      pixclk     = 1'b0;
      arstN     <= 1'b0;
      pixelData <= 8'h00;
      lcgState   = 32'h72025030;
      hModel     = 0;
      vModel     = 0;
      expNewFrame = 1'b0;
      expSymbols  = '0;
      expStage    = '0;
      resetState();
      activeVideo();
      blankingWords();
      coordinates();
      frameGeometry();
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
+incdir+verif
logic/dviPkg.sv
logic/videoTiming.sv
logic/tmdsEncoder.sv
logic/dviTransmitter.sv
verif/dviTransmitterTb.sv

// File: Makefile
# Verilator build and run of the DVI transmitter testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dviTransmitterTb
FLIST     = flist.f

OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SOURCES   = $(wildcard logic/*.sv logic/*.svh verif/*.sv verif/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# The status comes from the search for the pass line in the output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJDIR)
